// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int word_size     = 16;
    localparam int reg_count     = 4;
    localparam int reg_addr_size = 2;
    localparam int opcode_size   = 4;
    localparam int func_size     = 6;
    localparam int imm_size      = 8;
    localparam int alu_op_size   = 2;

    // opcodes in bits 15:12
    localparam logic [opcode_size-1:0] op_adi   = 4'd4;
    localparam logic [opcode_size-1:0] op_lwd   = 4'd7;
    localparam logic [opcode_size-1:0] op_swd   = 4'd8;
    localparam logic [opcode_size-1:0] op_rtype = 4'd15;

    // R-type function field, bits 5:0
    localparam logic [func_size-1:0] func_add = 6'd0;
    localparam logic [func_size-1:0] func_sub = 6'd1;
    localparam logic [func_size-1:0] func_and = 6'd2;
    localparam logic [func_size-1:0] func_orr = 6'd3;
    localparam logic [func_size-1:0] func_wwd = 6'd28;
    localparam logic [func_size-1:0] func_hlt = 6'd29;

    localparam logic [alu_op_size-1:0] alu_add = 2'd0;
    localparam logic [alu_op_size-1:0] alu_sub = 2'd1;
    localparam logic [alu_op_size-1:0] alu_and = 2'd2;
    localparam logic [alu_op_size-1:0] alu_orr = 2'd3;

    // ORR $0,$0,$0; decode turns this exact word into a bubble
    localparam logic [word_size-1:0] nop_word = {op_rtype, 2'd0, 2'd0, 2'd0, func_orr};

endpackage

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic [cpu_pkg::reg_addr_size-1:0] read_addr_a,
    input  logic [cpu_pkg::reg_addr_size-1:0] read_addr_b,
    input  logic [cpu_pkg::reg_addr_size-1:0] write_addr,
    input  logic [cpu_pkg::word_size-1:0]     write_data,
    input  logic                              write_enable,
    output logic [cpu_pkg::word_size-1:0]     read_data_a,
    output logic [cpu_pkg::word_size-1:0]     read_data_b
);

    logic [cpu_pkg::word_size-1:0] regs [cpu_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable) begin
            regs[write_addr] <= write_data;
        end
    end

    // write-through so decode sees a same-cycle writeback
    always_comb begin
        read_data_a = regs[read_addr_a];
        read_data_b = regs[read_addr_b];
        if (write_enable && write_addr == read_addr_a) read_data_a = write_data;
        if (write_enable && write_addr == read_addr_b) read_data_b = write_data;
    end

    wdata_known: assert property (@(posedge clk) disable iff (reset_n)
        write_enable |-> !$isunknown(write_data));

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [cpu_pkg::word_size-1:0]  instr_data,
    input  logic                           halt_fetch,
    output logic [cpu_pkg::word_size-1:0]  instr_address,
    output logic [cpu_pkg::word_size-1:0]  pc_id,
    output logic [cpu_pkg::word_size-1:0]  instr_id
);

    logic [cpu_pkg::word_size-1:0] pc;

    assign instr_address = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc       <= '0;
            pc_id    <= '0;
            instr_id <= cpu_pkg::nop_word;
        end else if (halt_fetch) begin
            instr_id <= cpu_pkg::nop_word; // pc frozen, feed bubbles
        end else begin
            pc       <= pc + 1'b1;
            pc_id    <= pc;
            instr_id <= instr_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic [cpu_pkg::word_size-1:0]     pc_id,
    input  logic [cpu_pkg::word_size-1:0]     instr_id,
    input  logic [cpu_pkg::reg_addr_size-1:0] wb_addr,
    input  logic [cpu_pkg::word_size-1:0]     wb_data,
    input  logic                              wb_enable,
    output logic                              halt_fetch,
    output logic [cpu_pkg::reg_addr_size-1:0] rs_ex,
    output logic [cpu_pkg::reg_addr_size-1:0] rt_ex,
    output logic [cpu_pkg::reg_addr_size-1:0] rd_ex,
    output logic [cpu_pkg::word_size-1:0]     op_a_ex,
    output logic [cpu_pkg::word_size-1:0]     op_b_ex,
    output logic [cpu_pkg::word_size-1:0]     imm_ex,
    output logic [cpu_pkg::alu_op_size-1:0]   alu_op_ex,
    output logic                              alu_src_imm_ex,
    output logic                              reg_write_ex,
    output logic                              mem_read_ex,
    output logic                              mem_write_ex,
    output logic                              mem_to_reg_ex,
    output logic                              is_wwd_ex,
    output logic                              is_hlt_ex
);

    logic [cpu_pkg::opcode_size-1:0]   opcode;
    logic [cpu_pkg::func_size-1:0]     func;
    logic [cpu_pkg::reg_addr_size-1:0] rs;
    logic [cpu_pkg::reg_addr_size-1:0] rt;
    logic [cpu_pkg::reg_addr_size-1:0] rd;
    logic [cpu_pkg::word_size-1:0]     rf_a;
    logic [cpu_pkg::word_size-1:0]     rf_b;
    logic [cpu_pkg::word_size-1:0]     imm;
    logic [cpu_pkg::alu_op_size-1:0]   alu_op;
    logic alu_src_imm, reg_write, mem_read, mem_write, mem_to_reg, is_wwd, is_hlt;
    logic halt_q;

    assign opcode = instr_id[cpu_pkg::word_size-1 -: cpu_pkg::opcode_size];
    assign func   = instr_id[cpu_pkg::func_size-1:0];
    assign rs     = instr_id[11:10];
    assign rt     = instr_id[9:8];
    assign imm    = {{(cpu_pkg::word_size - cpu_pkg::imm_size){instr_id[cpu_pkg::imm_size-1]}},
                     instr_id[cpu_pkg::imm_size-1:0]};

    register_file i_register_file (
        .clk          (clk),
        .reset_n      (reset_n),
        .read_addr_a  (rs),
        .read_addr_b  (rt),
        .write_addr   (wb_addr),
        .write_data   (wb_data),
        .write_enable (wb_enable),
        .read_data_a  (rf_a),
        .read_data_b  (rf_b)
    );

    always_comb begin
        alu_op      = cpu_pkg::alu_add;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        is_wwd      = 1'b0;
        is_hlt      = 1'b0;
        rd          = rt; // ADI and LWD write rt
        case (opcode)
            cpu_pkg::op_adi: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            cpu_pkg::op_lwd: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
                mem_to_reg  = 1'b1;
            end
            cpu_pkg::op_swd: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            cpu_pkg::op_rtype: begin
                rd = instr_id[7:6];
                if (instr_id != cpu_pkg::nop_word) begin
                    case (func)
                        cpu_pkg::func_add: reg_write = 1'b1;
                        cpu_pkg::func_sub: begin
                            reg_write = 1'b1;
                            alu_op    = cpu_pkg::alu_sub;
                        end
                        cpu_pkg::func_and: begin
                            reg_write = 1'b1;
                            alu_op    = cpu_pkg::alu_and;
                        end
                        cpu_pkg::func_orr: begin
                            reg_write = 1'b1;
                            alu_op    = cpu_pkg::alu_orr;
                        end
                        cpu_pkg::func_wwd: is_wwd = 1'b1;
                        cpu_pkg::func_hlt: is_hlt = 1'b1;
                        default: ;
                    endcase
                end
            end
            default: ; // unknown opcode, bubble
        endcase
    end

    assign halt_fetch = halt_q | is_hlt;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_q         <= 1'b0;
            reg_write_ex   <= 1'b0;
            mem_read_ex    <= 1'b0;
            mem_write_ex   <= 1'b0;
            mem_to_reg_ex  <= 1'b0;
            is_wwd_ex      <= 1'b0;
            is_hlt_ex      <= 1'b0;
            alu_src_imm_ex <= 1'b0;
            alu_op_ex      <= cpu_pkg::alu_add;
        end else begin
            halt_q         <= halt_fetch; // sticky until reset
            reg_write_ex   <= reg_write;
            mem_read_ex    <= mem_read;
            mem_write_ex   <= mem_write;
            mem_to_reg_ex  <= mem_to_reg;
            is_wwd_ex      <= is_wwd;
            is_hlt_ex      <= is_hlt;
            alu_src_imm_ex <= alu_src_imm;
            alu_op_ex      <= alu_op;
        end
    end

    always_ff @(posedge clk) begin
        rs_ex   <= rs;
        rt_ex   <= rt;
        rd_ex   <= rd;
        op_a_ex <= rf_a;
        op_b_ex <= rf_b;
        imm_ex  <= imm;
    end

    no_read_and_write: assert property (@(posedge clk) disable iff (reset_n)
        !(mem_read_ex && mem_write_ex));

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic [cpu_pkg::reg_addr_size-1:0] rs_ex,
    input  logic [cpu_pkg::reg_addr_size-1:0] rt_ex,
    input  logic [cpu_pkg::reg_addr_size-1:0] rd_ex,
    input  logic [cpu_pkg::word_size-1:0]     op_a_ex,
    input  logic [cpu_pkg::word_size-1:0]     op_b_ex,
    input  logic [cpu_pkg::word_size-1:0]     imm_ex,
    input  logic [cpu_pkg::alu_op_size-1:0]   alu_op_ex,
    input  logic                              alu_src_imm_ex,
    input  logic                              reg_write_ex,
    input  logic                              mem_read_ex,
    input  logic                              mem_write_ex,
    input  logic                              mem_to_reg_ex,
    input  logic                              is_wwd_ex,
    input  logic                              is_hlt_ex,
    input  logic [cpu_pkg::reg_addr_size-1:0] mem_rd,
    input  logic                              mem_reg_write,
    input  logic [cpu_pkg::word_size-1:0]     mem_result,
    input  logic [cpu_pkg::reg_addr_size-1:0] wb_addr,
    input  logic                              wb_enable,
    input  logic [cpu_pkg::word_size-1:0]     wb_data,
    output logic [cpu_pkg::word_size-1:0]     alu_result_mem,
    output logic [cpu_pkg::word_size-1:0]     store_data_mem,
    output logic [cpu_pkg::reg_addr_size-1:0] rd_mem,
    output logic                              reg_write_mem,
    output logic                              mem_read_mem,
    output logic                              mem_write_mem,
    output logic                              mem_to_reg_mem,
    output logic                              is_wwd_mem,
    output logic                              is_hlt_mem
);

    logic [cpu_pkg::word_size-1:0] fwd_a;
    logic [cpu_pkg::word_size-1:0] fwd_b;
    logic [cpu_pkg::word_size-1:0] alu_b;
    logic [cpu_pkg::word_size-1:0] alu_out;
    logic uses_a, uses_b;

    // newest producer wins
    always_comb begin
        fwd_a = op_a_ex;
        fwd_b = op_b_ex;
        if (mem_reg_write && mem_rd == rs_ex) fwd_a = mem_result;
        else if (wb_enable && wb_addr == rs_ex) fwd_a = wb_data;
        if (mem_reg_write && mem_rd == rt_ex) fwd_b = mem_result;
        else if (wb_enable && wb_addr == rt_ex) fwd_b = wb_data;
    end

    assign alu_b = alu_src_imm_ex ? imm_ex : fwd_b;

    always_comb begin
        case (alu_op_ex)
            cpu_pkg::alu_add: alu_out = fwd_a + alu_b;
            cpu_pkg::alu_sub: alu_out = fwd_a - alu_b;
            cpu_pkg::alu_and: alu_out = fwd_a & alu_b;
            cpu_pkg::alu_orr: alu_out = fwd_a | alu_b;
            default:          alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            reg_write_mem  <= 1'b0;
            mem_read_mem   <= 1'b0;
            mem_write_mem  <= 1'b0;
            mem_to_reg_mem <= 1'b0;
            is_wwd_mem     <= 1'b0;
            is_hlt_mem     <= 1'b0;
        end else begin
            reg_write_mem  <= reg_write_ex;
            mem_read_mem   <= mem_read_ex;
            mem_write_mem  <= mem_write_ex;
            mem_to_reg_mem <= mem_to_reg_ex;
            is_wwd_mem     <= is_wwd_ex;
            is_hlt_mem     <= is_hlt_ex;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_mem <= is_wwd_ex ? fwd_a : alu_out; // WWD passes rs through
        store_data_mem <= fwd_b;
        rd_mem         <= rd_ex;
    end

    // which operands the instruction in execute really reads
    assign uses_a = reg_write_ex | mem_write_ex | is_wwd_ex;
    assign uses_b = (reg_write_ex & ~alu_src_imm_ex) | mem_write_ex;

    // load data is not ready for forwarding until writeback
    no_load_use: assert property (@(posedge clk) disable iff (reset_n)
        !(mem_read_mem && mem_reg_write &&
          ((uses_a && mem_rd == rs_ex) || (uses_b && mem_rd == rt_ex))));

endmodule

`default_nettype wire

// ==== hw/memory_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_writeback (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic [cpu_pkg::word_size-1:0]     alu_result_mem,
    input  logic [cpu_pkg::word_size-1:0]     store_data_mem,
    input  logic [cpu_pkg::reg_addr_size-1:0] rd_mem,
    input  logic                              reg_write_mem,
    input  logic                              mem_read_mem,
    input  logic                              mem_write_mem,
    input  logic                              mem_to_reg_mem,
    input  logic                              is_wwd_mem,
    input  logic                              is_hlt_mem,
    input  logic [cpu_pkg::word_size-1:0]     read_data,
    output logic                              mem_read,
    output logic                              mem_write,
    output logic [cpu_pkg::word_size-1:0]     data_address,
    output logic [cpu_pkg::word_size-1:0]     write_data,
    output logic [cpu_pkg::reg_addr_size-1:0] mem_rd,
    output logic                              mem_reg_write,
    output logic [cpu_pkg::word_size-1:0]     mem_result,
    output logic [cpu_pkg::reg_addr_size-1:0] wb_addr,
    output logic [cpu_pkg::word_size-1:0]     wb_data,
    output logic                              wb_enable,
    output logic [cpu_pkg::word_size-1:0]     output_port,
    output logic                              output_strobe,
    output logic [cpu_pkg::word_size-1:0]     num_inst,
    output logic                              is_halted
);

    logic [cpu_pkg::word_size-1:0] alu_result_wb;
    logic [cpu_pkg::word_size-1:0] load_data_wb;
    logic mem_to_reg_wb;
    logic retire_mem;

    assign mem_read     = mem_read_mem;
    assign mem_write    = mem_write_mem;
    assign data_address = alu_result_mem;
    assign write_data   = store_data_mem;

    assign mem_rd        = rd_mem;
    assign mem_reg_write = reg_write_mem;
    assign mem_result    = alu_result_mem;

    // every real instruction sets at least one of these
    assign retire_mem = reg_write_mem | mem_write_mem | is_wwd_mem | is_hlt_mem;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_enable     <= 1'b0;
            mem_to_reg_wb <= 1'b0;
            output_port   <= '0;
            output_strobe <= 1'b0;
            num_inst      <= '0;
            is_halted     <= 1'b0;
        end else begin
            wb_enable     <= reg_write_mem;
            mem_to_reg_wb <= mem_to_reg_mem;
            output_strobe <= is_wwd_mem;
            if (is_wwd_mem) output_port <= alu_result_mem;
            if (retire_mem) num_inst <= num_inst + 1'b1;
            if (is_hlt_mem) is_halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr       <= rd_mem;
        alu_result_wb <= alu_result_mem;
        load_data_wb  <= read_data;
    end

    assign wb_data = mem_to_reg_wb ? load_data_wb : alu_result_wb;

    // only bubbles may follow HLT down the pipe
    count_frozen: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> $stable(num_inst));

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [cpu_pkg::word_size-1:0] instr_data,
    input  logic [cpu_pkg::word_size-1:0] read_data,
    output logic [cpu_pkg::word_size-1:0] instr_address,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic [cpu_pkg::word_size-1:0] data_address,
    output logic [cpu_pkg::word_size-1:0] write_data,
    output logic [cpu_pkg::word_size-1:0] output_port,
    output logic                          output_strobe,
    output logic [cpu_pkg::word_size-1:0] num_inst,
    output logic                          is_halted
);

    // fetch to decode
    logic [cpu_pkg::word_size-1:0]     pc_id;
    logic [cpu_pkg::word_size-1:0]     instr_id;
    logic                              halt_fetch;

    // decode to execute
    logic [cpu_pkg::reg_addr_size-1:0] rs_ex, rt_ex, rd_ex;
    logic [cpu_pkg::word_size-1:0]     op_a_ex, op_b_ex, imm_ex;
    logic [cpu_pkg::alu_op_size-1:0]   alu_op_ex;
    logic alu_src_imm_ex, reg_write_ex, mem_read_ex, mem_write_ex;
    logic mem_to_reg_ex, is_wwd_ex, is_hlt_ex;

    // execute to memory
    logic [cpu_pkg::word_size-1:0]     alu_result_mem, store_data_mem;
    logic [cpu_pkg::reg_addr_size-1:0] rd_mem;
    logic reg_write_mem, mem_read_mem, mem_write_mem;
    logic mem_to_reg_mem, is_wwd_mem, is_hlt_mem;

    // forwarding and register writeback
    logic [cpu_pkg::reg_addr_size-1:0] mem_rd, wb_addr;
    logic [cpu_pkg::word_size-1:0]     mem_result, wb_data;
    logic                              mem_reg_write, wb_enable;

    fetch_stage      i_fetch_stage      (.*);
    decode_stage     i_decode_stage     (.*);
    execute_stage    i_execute_stage    (.*);
    memory_writeback i_memory_writeback (.*);

endmodule

`default_nettype wire

// ==== include/cpu_tb_program.svh ====
// instruction words, fetched in order from address 0
localparam int prog_len          = 23;
localparam int halt_retire_count = 21; // up to and including HLT

localparam logic [cpu_pkg::word_size-1:0] prog_words [prog_len] = '{
    16'h4135, // ADI $1,$0,0x35   $1 = 0035
    16'h46fd, // ADI $2,$1,-3     $2 = 0032
    16'hf6c0, // ADD $3,$1,$2     $3 = 0067
    16'hfc1c, // WWD $3
    16'hf701, // SUB $0,$1,$3     $0 = ffce
    16'hf342, // AND $1,$0,$3     $1 = 0046
    16'hf683, // ORR $2,$1,$2     $2 = 0076
    16'hf01c, // WWD $0           third after SUB, register file write-through
    16'hf81c, // WWD $2
    16'h8e10, // SWD $2,$3,0x10   mem[0077] = 0076
    16'h4011, // ADI $0,$0,0x11   $0 = ffdf
    16'h8402, // SWD $0,$1,2      mem[0048] = ffdf
    16'h7731, // LWD $3,$1,0x31   $3 = mem[0077]
    16'h78ca, // LWD $0,$2,-0x36  $0 = mem[0040]
    16'h4a01, // ADI $2,$2,1      $2 = 0077
    16'hf941, // SUB $1,$2,$1     $1 = 0031
    16'hfc1c, // WWD $3
    16'hf01c, // WWD $0
    16'hf180, // ADD $2,$0,$1     $2 = 1265
    16'hf81c, // WWD $2
    16'hf01d, // HLT
    16'hf41c, // WWD $1, squashed by the halt
    16'h8e10  // SWD, never fetched
};

// initial data memory contents
localparam int data_count = 2;
localparam logic [cpu_pkg::word_size-1:0] data_init_addr  [data_count] = '{16'h0040, 16'h0041};
localparam logic [cpu_pkg::word_size-1:0] data_init_value [data_count] = '{16'h1234, 16'hbeef};

// WWD values in retire order
localparam int out_count = 6;
localparam logic [cpu_pkg::word_size-1:0] expected_out [out_count] = '{
    16'h0067, 16'hffce, 16'h0076, 16'h0076, 16'h1234, 16'h1265
};

// stores in program order
localparam int store_count = 2;
localparam logic [cpu_pkg::word_size-1:0] store_addr  [store_count] = '{16'h0077, 16'h0048};
localparam logic [cpu_pkg::word_size-1:0] store_value [store_count] = '{16'h0076, 16'hffdf};

// loads in program order
localparam int load_count = 2;
localparam logic [cpu_pkg::word_size-1:0] load_addr [load_count] = '{16'h0077, 16'h0040};

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

    `include "cpu_tb_program.svh"

    localparam int timeout_cycles = 8 * prog_len + 20;
    localparam int drain_cycles   = 8; // cycles watched once halted

    logic                          clk;
    logic                          reset_n;
    logic [cpu_pkg::word_size-1:0] instr_data;
    logic [cpu_pkg::word_size-1:0] read_data;
    logic [cpu_pkg::word_size-1:0] instr_address;
    logic                          mem_read;
    logic                          mem_write;
    logic [cpu_pkg::word_size-1:0] data_address;
    logic [cpu_pkg::word_size-1:0] write_data;
    logic [cpu_pkg::word_size-1:0] output_port;
    logic                          output_strobe;
    logic [cpu_pkg::word_size-1:0] num_inst;
    logic                          is_halted;

    logic [cpu_pkg::word_size-1:0] instr_mem [256];
    logic [cpu_pkg::word_size-1:0] data_mem [65536];

    int                            cycle_count;
    int                            out_index;
    int                            store_index;
    int                            load_index;
    int                            halt_cycles;
    logic [cpu_pkg::word_size-1:0] frozen_pc;

    cpu_top i_cpu_top (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_data    (instr_data),
        .read_data     (read_data),
        .instr_address (instr_address),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .data_address  (data_address),
        .write_data    (write_data),
        .output_port   (output_port),
        .output_strobe (output_strobe),
        .num_inst      (num_inst),
        .is_halted     (is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // both memories answer in the same cycle
    always_comb begin
        instr_data = cpu_pkg::nop_word;
        if (!$isunknown(instr_address)) instr_data = instr_mem[instr_address[7:0]];
    end

    always_comb begin
        read_data = '0;
        if (!$isunknown(data_address)) read_data = data_mem[data_address];
    end

    always @(posedge clk) begin
        if (mem_write) data_mem[data_address] <= write_data;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic load_memories();
        logic [15:0] addr;
        for (int a = 0; a < 256; a++) begin
            instr_mem[a] = {4'h0, 12'(a)}; // opcode 0 decodes as a bubble
        end
        for (int a = 0; a < 65536; a++) begin
            addr        = 16'(a);
            data_mem[a] = {addr[7:0], addr[15:8]} ^ 16'h5aa5;
        end
        for (int i = 0; i < prog_len; i++) begin
            instr_mem[i] = prog_words[i];
        end
        for (int i = 0; i < data_count; i++) begin
            data_mem[data_init_addr[i]] = data_init_value[i];
        end
    endtask

    task automatic check_reset_state();
        assert (mem_read == 1'b0) else report_mismatch("mem_read", 16'h0, 16'(mem_read));
        assert (mem_write == 1'b0) else report_mismatch("mem_write", 16'h0, 16'(mem_write));
        assert (output_strobe == 1'b0)
            else report_mismatch("output_strobe", 16'h0, 16'(output_strobe));
        assert (is_halted == 1'b0) else report_mismatch("is_halted", 16'h0, 16'(is_halted));
        assert (num_inst == 16'h0) else report_mismatch("num_inst", 16'h0, num_inst);
    endtask

    task automatic check_cycle();
        if (is_halted) begin
            assert (output_strobe == 1'b0) else report_failure("output_strobe pulsed after halt");
            assert (mem_read == 1'b0) else report_failure("mem_read raised after halt");
            assert (mem_write == 1'b0) else report_failure("mem_write raised after halt");
            if (halt_cycles == 0) begin
                assert (num_inst == 16'(halt_retire_count))
                    else report_mismatch("num_inst", 16'(halt_retire_count), num_inst);
                frozen_pc = instr_address;
            end else begin
                assert (instr_address == frozen_pc)
                    else report_mismatch("instr_address", frozen_pc, instr_address);
            end
            halt_cycles++;
        end else begin
            assert (halt_cycles == 0) else report_failure("is_halted dropped after rising");
        end
        if (output_strobe) begin
            assert (out_index < out_count) else report_failure("more WWD outputs than expected");
            assert (output_port == expected_out[out_index])
                else report_mismatch("output_port", expected_out[out_index], output_port);
            out_index++;
        end
        if (mem_write) begin
            assert (store_index < store_count) else report_failure("more stores than expected");
            assert (data_address == store_addr[store_index])
                else report_mismatch("data_address", store_addr[store_index], data_address);
            assert (write_data == store_value[store_index])
                else report_mismatch("write_data", store_value[store_index], write_data);
            store_index++;
        end
        if (mem_read) begin
            assert (load_index < load_count) else report_failure("more loads than expected");
            assert (data_address == load_addr[load_index])
                else report_mismatch("data_address", load_addr[load_index], data_address);
            load_index++;
        end
    endtask

    initial begin
        reset_n     = 1'b1; // reset is asserted high
        cycle_count = 0;
        out_index   = 0;
        store_index = 0;
        load_index  = 0;
        halt_cycles = 0;
        frozen_pc   = '0;
        load_memories();
        repeat (5) begin
            @(negedge clk);
            check_reset_state();
        end
        reset_n = 1'b0;
        while (halt_cycles < drain_cycles) begin
            @(negedge clk);
            cycle_count++;
            assert (cycle_count < timeout_cycles)
                else report_failure("timeout, the processor did not halt in time");
            if (cycle_count == 1) check_reset_state();
            check_cycle();
        end
        assert (out_index == out_count)
            else report_mismatch("output_strobe count", 16'(out_count), 16'(out_index));
        assert (store_index == store_count)
            else report_mismatch("mem_write count", 16'(store_count), 16'(store_index));
        assert (load_index == load_count)
            else report_mismatch("mem_read count", 16'(load_count), 16'(load_index));
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hw/cpu_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_writeback.sv
hw/cpu_top.sv
bench/cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '^Finished with no errors$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
